//--- tb.f
verilog/cam_stream_pkg.sv
verilog/pix_wr_if.sv
verilog/frame_marker_insert.sv
verilog/packet_stream_fifo.sv
verilog/stream_activity_monitor.sv
verilog/cam_usb_stream_top.sv
test/cam_usb_stream_asserts.sv
test/tb_cam_usb_stream.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cam_usb_stream
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SIM       = $(OBJ_DIR)/V$(TOP)
SRCS      = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/tb_cam_usb_stream.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cam_usb_stream;

  localparam int unsigned MARKER_LEN        = 8;
  localparam int unsigned FIFO_WORDS        = 64;
  localparam int unsigned PKT_BYTES         = 16;
  localparam int unsigned PROBE_HALF_PERIOD = 5;
  localparam int unsigned SEED              = 32'ha88b_fd57;
  localparam int          NUM_TESTS         = 5;
  localparam int          NUM_SEGS          = 17;

  typedef struct packed {
    int         test;      // Index into test_name
    int         count;     // Steps in this segment
    logic       vsync;
    logic       href;
    logic       pop;
    logic [2:0] led_mask;  // LED bits checked after the last step
    logic [2:0] led_exp;
  } seg_t;

  typedef struct packed {
    int                        test;
    logic                      vsync;
    logic                      href;
    logic                      pop;
    logic [2:0]                led_mask;
    logic [2:0]                led_exp;
    cam_stream_pkg::pix_word_t pix;
  } step_t;

  logic                      cmos_pclk;
  logic                      I_rst_n;
  logic                      cmos_vsync_i;
  logic                      cmos_href_i;
  cam_stream_pkg::pix_word_t cmos_db_i;
  logic                      usb_pop_i;
  cam_stream_pkg::usb_byte_t usb_byte_o;
  logic                      usb_valid_o;
  logic                      probe_o;
  logic [2:0]                led_o;

  seg_t  segs [NUM_SEGS];
  step_t steps [$];
  string test_name [NUM_TESTS] = '{"packet gate", "reorder and byte order",
                                   "marker burst", "back-pressure", "probe"};
  int    test_checks [NUM_TESTS] = '{default: 0};
  int    test_errs [NUM_TESTS] = '{default: 0};
  int    checks = 0;
  int    errors = 0;
  int    cur_test = 0;
  int    cycle_cnt = 0;
  int    cycle_limit = 0;  // Zero until the table is built

  // Reference model state
  logic [7:0] ref_q [$];     // Bytes in pop order
  logic       m_insert = 1'b0;
  int         m_cnt = 0;
  logic       m_vs_q = 1'b0;
  int         m_strobes = 0;
  logic       m_probe = 1'b0;
  logic       m_valid = 1'b0;
  logic [7:0] m_byte = '0;
  logic [2:0] pend_mask = '0;  // Table LED check for the step just clocked
  logic [2:0] pend_exp = '0;

  cam_usb_stream_top #(
    .MARKER_LEN        (MARKER_LEN),
    .FIFO_WORDS        (FIFO_WORDS),
    .PKT_BYTES         (PKT_BYTES),
    .PROBE_HALF_PERIOD (PROBE_HALF_PERIOD)
  ) DUT (
    .cmos_pclk    (cmos_pclk),
    .I_rst_n      (I_rst_n),
    .cmos_vsync_i (cmos_vsync_i),
    .cmos_href_i  (cmos_href_i),
    .cmos_db_i    (cmos_db_i),
    .usb_pop_i    (usb_pop_i),
    .usb_byte_o   (usb_byte_o),
    .usb_valid_o  (usb_valid_o),
    .probe_o      (probe_o),
    .led_o        (led_o)
  );

  initial begin
    cmos_pclk = 1'b0;
    forever #20 cmos_pclk = ~cmos_pclk;  // 40 ns period
  end

  // =========================================================================
  // Reference model
  // =========================================================================

  // Red from bits 4..0 on top, blue from bits 15..11 at the bottom
  function automatic cam_stream_pkg::pix_word_t reorder_pix(input logic [15:0] p);
    return {p[4:0], p[10:5], p[15:11]};
  endfunction

  function automatic int word_count();
    return (ref_q.size() + 1) / 2;  // Half-read word still occupies a slot
  endfunction

  function automatic logic model_full();
    return word_count() == FIFO_WORDS;
  endfunction

  function automatic logic model_afull();
    return word_count() > FIFO_WORDS - cam_stream_pkg::AFULL_MARGIN;
  endfunction

  task automatic advance_model(input step_t st);
    logic                      full;
    logic                      afull;
    logic                      rise;
    logic                      cam_wr;
    logic                      pop_ok;
    cam_stream_pkg::pix_word_t data;
    full   = model_full();
    afull  = model_afull();
    rise   = st.vsync & ~m_vs_q & ~m_insert;
    cam_wr = ~m_insert & st.href & ~afull;  // Camera dropped in a burst
    data   = m_insert ? cam_stream_pkg::MARKER_WORD : reorder_pix(st.pix);
    pop_ok = st.pop && (ref_q.size() >= PKT_BYTES);
    m_valid = pop_ok;
    if (pop_ok) m_byte = ref_q.pop_front();
    if ((m_insert || cam_wr) && !full) begin
      ref_q.push_back(data[7:0]);   // Low byte leaves first
      ref_q.push_back(data[15:8]);
    end
    if (m_insert) begin
      if (m_cnt == MARKER_LEN) m_insert = 1'b0;
      else m_cnt++;
    end else if (rise) begin
      m_insert = 1'b1;
      m_cnt    = 0;
    end
    m_vs_q = st.vsync;
    if (cam_wr) begin
      if (m_strobes == PROBE_HALF_PERIOD - 1) begin
        m_strobes = 0;
        m_probe   = ~m_probe;
      end else begin
        m_strobes++;
      end
    end
  endtask

  // =========================================================================
  // Checks and reporting
  // =========================================================================

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    test_checks[cur_test]++;
    if (got !== exp) begin
      errors++;
      test_errs[cur_test]++;
      $display("mismatch at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic check_outputs();
    logic [2:0] exp_led;
    exp_led = {~m_probe, ~model_afull(), ~model_full()};  // Active low
    check_value("usb_valid_o", 16'(usb_valid_o), 16'(m_valid));
    if (m_valid) check_value("usb_byte_o", 16'(usb_byte_o), 16'(m_byte));
    check_value("probe_o", 16'(probe_o), 16'(m_probe));
    check_value("led_o", 16'(led_o), 16'(exp_led));
    if (pend_mask != 3'b000) begin
      check_value("led_o", 16'(led_o & pend_mask), 16'(pend_exp & pend_mask));
    end
  endtask

  task automatic report_test(input int t);
    $display("test %0d %s done: %0d checks, %0d errors",
             t, test_name[t], test_checks[t], test_errs[t]);
  endtask

  initial begin : watchdog
    wait (cycle_limit != 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge cmos_pclk);
      cycle_cnt++;
    end
    $display("timeout: run still going after %0d cycles", cycle_cnt);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // =========================================================================
  // Stimulus table and main sequence
  // =========================================================================

  initial begin : main
    step_t st;
    void'($urandom(SEED));
    cmos_vsync_i = 1'b0;
    cmos_href_i  = 1'b0;
    cmos_db_i    = '0;
    usb_pop_i    = 1'b0;
    I_rst_n      = 1'b0;
    //          test cnt vsync href  pop   mask    exp
    segs = '{'{0,  3, 1'b0, 1'b0, 1'b1, 3'b000, 3'b000},  // Pops on empty FIFO
             '{0,  4, 1'b0, 1'b1, 1'b0, 3'b000, 3'b000},
             '{0,  3, 1'b0, 1'b0, 1'b1, 3'b000, 3'b000},  // Half a packet
             '{0,  4, 1'b0, 1'b1, 1'b0, 3'b000, 3'b000},
             '{0,  4, 1'b0, 1'b0, 1'b1, 3'b000, 3'b000},  // Only the first goes
             '{1,  8, 1'b0, 1'b1, 1'b0, 3'b000, 3'b000},  // 8 random pixels
             '{1, 16, 1'b0, 1'b1, 1'b1, 3'b000, 3'b000},
             '{2,  1, 1'b1, 1'b1, 1'b0, 3'b000, 3'b000},  // Vsync rise
             '{2, 12, 1'b1, 1'b1, 1'b1, 3'b000, 3'b000},  // Camera dropped
             '{2, 50, 1'b0, 1'b1, 1'b1, 3'b000, 3'b000},  // Markers come out
             '{3, 40, 1'b0, 1'b1, 1'b0, 3'b011, 3'b001},  // Almost full
             '{3,  1, 1'b1, 1'b1, 1'b0, 3'b000, 3'b000},
             '{3, 12, 1'b1, 1'b1, 1'b0, 3'b011, 3'b000},  // Markers fill it
             '{4, 60, 1'b0, 1'b0, 1'b1, 3'b011, 3'b011},  // Drain
             '{4, 20, 1'b0, 1'b1, 1'b0, 3'b000, 3'b000},
             '{4,  7, 1'b0, 1'b0, 1'b0, 3'b000, 3'b000},
             '{4, 13, 1'b0, 1'b1, 1'b0, 3'b011, 3'b001}};  // Blocked near full
    for (int s = 0; s < NUM_SEGS; s++) begin
      for (int k = 0; k < segs[s].count; k++) begin
        st.test     = segs[s].test;
        st.vsync    = segs[s].vsync;
        st.href     = segs[s].href;
        st.pop      = segs[s].pop;
        st.led_mask = (k == segs[s].count - 1) ? segs[s].led_mask : 3'b000;
        st.led_exp  = segs[s].led_exp;
        st.pix      = 16'($urandom());
        steps.push_back(st);
      end
    end
    cycle_limit = 2 * steps.size() + 200;

    repeat (2) @(posedge cmos_pclk);
    #2 I_rst_n = 1'b1;
    foreach (steps[i]) begin
      check_outputs();  // Results of the previous edge
      if (steps[i].test != cur_test) begin
        report_test(cur_test);
        cur_test = steps[i].test;
      end
      cmos_vsync_i = steps[i].vsync;
      cmos_href_i  = steps[i].href;
      cmos_db_i    = steps[i].pix;
      usb_pop_i    = steps[i].pop;
      advance_model(steps[i]);
      pend_mask = steps[i].led_mask;
      pend_exp  = steps[i].led_exp;
      @(posedge cmos_pclk);
      #2;
    end
    check_outputs();
    report_test(cur_test);
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/cam_usb_stream_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module cam_usb_stream_asserts #(
  parameter int unsigned MARKER_LEN = 1000,  // Burst is MARKER_LEN+1 words
  parameter int unsigned FIFO_WORDS = 2048,  // FIFO depth in words
  parameter int unsigned PKT_BYTES  = 512    // Bytes needed before a pop
) (
  input wire cmos_pclk,
  input wire I_rst_n,
  input wire usb_pop_i,    // Pop request at the top
  input wire usb_valid_i,  // Byte valid at the top
  input wire wr_ok_i,      // Word stored by the FIFO
  input wire in_burst_i    // Marker FSM in MARK_INSERT
);

  int unsigned burst_len;     // Cycles spent in the current burst
  int          bytes_seen_q;  // Bytes written minus bytes already shown valid
  int          bytes_held;    // Bytes in the FIFO this cycle

  // A byte shown valid now was popped at the edge before
  assign bytes_held = bytes_seen_q - (usb_valid_i ? 1 : 0);

  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      burst_len <= 0;
    end else if (in_burst_i) begin
      burst_len <= burst_len + 1;
    end else begin
      burst_len <= 0;  // Ready for the next frame
    end
  end

  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      bytes_seen_q <= 0;
    end else begin
      bytes_seen_q <= bytes_seen_q + (wr_ok_i ? 2 : 0) - (usb_valid_i ? 1 : 0);
    end
  end

  // =========================================================================
  // Properties
  // =========================================================================

  valid_needs_pop: assert property (@(posedge cmos_pclk) disable iff (!I_rst_n)
    usb_valid_i |-> $past(usb_pop_i && (bytes_held >= int'(PKT_BYTES))))
    else $error("usb_valid_o high without a pop on a whole packet one cycle before");

  // A half-read word still holds its slot
  no_store_when_full: assert property (@(posedge cmos_pclk) disable iff (!I_rst_n)
    wr_ok_i |-> (bytes_held <= int'(2 * FIFO_WORDS) - 2))
    else $error("word stored while the FIFO was full");

  burst_length: assert property (@(posedge cmos_pclk) disable iff (!I_rst_n)
    $fell(in_burst_i) |-> (burst_len == MARKER_LEN + 1))
    else $error("marker burst length differs from MARKER_LEN+1");

endmodule

bind cam_usb_stream_top cam_usb_stream_asserts #(
  .MARKER_LEN (MARKER_LEN),
  .FIFO_WORDS (FIFO_WORDS),
  .PKT_BYTES  (PKT_BYTES)
) u_asserts (
  .cmos_pclk   (cmos_pclk),
  .I_rst_n     (I_rst_n),
  .usb_pop_i   (usb_pop_i),
  .usb_valid_i (usb_valid_o),
  .wr_ok_i     (u_fifo.wr_ok),
  .in_burst_i  (u_marker.in_burst)
);

`default_nettype wire

//--- verilog/cam_usb_stream_top.sv
`timescale 1ns/10ps
`default_nettype none

module cam_usb_stream_top #(
  parameter int unsigned MARKER_LEN        = 1000,     // Marker burst is this plus one
  parameter int unsigned FIFO_WORDS        = 2048,     // FIFO depth in words
  parameter int unsigned PKT_BYTES         = 512,      // USB packet size
  parameter int unsigned PROBE_HALF_PERIOD = 7903334   // Strobes per probe toggle
) (
  input  wire                            cmos_pclk,     // Camera pixel clock
  input  wire                            I_rst_n,
  input  wire                            cmos_vsync_i,  // Frame sync
  input  wire                            cmos_href_i,   // Pixel valid
  input  wire cam_stream_pkg::pix_word_t cmos_db_i,     // 16-bit camera word
  input  wire                            usb_pop_i,     // Transmit pop
  output wire cam_stream_pkg::usb_byte_t usb_byte_o,
  output wire                            usb_valid_o,
  output wire                            probe_o,
  output wire [2:0]                      led_o
);

  pix_wr_if wr_if ();  // Marker to FIFO write path

  logic cam_wr;  // Camera word stored this cycle

  // =========================================================================
  // Pixel path
  // =========================================================================

  frame_marker_insert #(
    .MARKER_LEN (MARKER_LEN)
  ) u_marker (
    .cmos_pclk (cmos_pclk),
    .I_rst_n   (I_rst_n),
    .vsync_i   (cmos_vsync_i),
    .href_i    (cmos_href_i),
    .pix_i     (cmos_db_i),
    .wr_if     (wr_if.writer),
    .cam_wr_o  (cam_wr)
  );

  packet_stream_fifo #(
    .FIFO_WORDS (FIFO_WORDS),
    .PKT_BYTES  (PKT_BYTES)
  ) u_fifo (
    .cmos_pclk   (cmos_pclk),
    .I_rst_n     (I_rst_n),
    .usb_pop_i   (usb_pop_i),
    .wr_if       (wr_if.fifo),
    .usb_byte_o  (usb_byte_o),
    .usb_valid_o (usb_valid_o)
  );

  // =========================================================================
  // Status
  // =========================================================================

  stream_activity_monitor #(
    .PROBE_HALF_PERIOD (PROBE_HALF_PERIOD)
  ) u_monitor (
    .cmos_pclk     (cmos_pclk),
    .I_rst_n       (I_rst_n),
    .cam_wr_i      (cam_wr),
    .full_i        (wr_if.full),
    .almost_full_i (wr_if.almost_full),
    .probe_o       (probe_o),
    .led_o         (led_o)
  );

endmodule

`default_nettype wire

//--- verilog/stream_activity_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module stream_activity_monitor #(
  parameter int unsigned PROBE_HALF_PERIOD = 7903334  // Strobes per probe half period
) (
  input  wire        cmos_pclk,
  input  wire        I_rst_n,
  input  wire        cam_wr_i,       // Accepted camera word
  input  wire        full_i,         // FIFO full
  input  wire        almost_full_i,  // FIFO almost full
  output logic       probe_o,        // Frame-rate probe square wave
  output logic [2:0] led_o           // Status LEDs, active low
);

  localparam int unsigned CW = $clog2(PROBE_HALF_PERIOD + 1);
  localparam logic [CW-1:0] LAST_STROBE = CW'(PROBE_HALF_PERIOD - 1);

  // =========================================================================
  // Frame-rate probe
  // =========================================================================

  logic [CW-1:0] strobe_cnt;  // Camera strobes in this half period

  // Counts only accepted camera words, markers and blocked strobes excluded
  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      strobe_cnt <= '0;
      probe_o    <= 1'b0;
    end else if (cam_wr_i) begin
      if (strobe_cnt == LAST_STROBE) begin
        strobe_cnt <= '0;         // Start next half period
        probe_o    <= ~probe_o;   // Toggle on the last strobe
      end else begin
        strobe_cnt <= strobe_cnt + 1'b1;
      end
    end
  end

  // =========================================================================
  // Status LEDs
  // =========================================================================

  assign led_o[0] = ~full_i;         // Lit when FIFO full
  assign led_o[1] = ~almost_full_i;  // Lit when nearly full
  assign led_o[2] = ~probe_o;        // Blinks with the probe, off after reset

endmodule

`default_nettype wire

//--- verilog/packet_stream_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module packet_stream_fifo #(
  parameter int unsigned FIFO_WORDS = 2048,  // Word depth, power of two
  parameter int unsigned PKT_BYTES  = 512    // Bytes needed before a pop
) (
  input  wire                             cmos_pclk,
  input  wire                             I_rst_n,
  input  wire                             usb_pop_i,    // Controller wants a byte
  pix_wr_if.fifo                          wr_if,        // Word write side
  output cam_stream_pkg::usb_byte_t       usb_byte_o,   // Popped byte
  output logic                            usb_valid_o   // One cycle after a pop
);

  localparam int unsigned AW = $clog2(FIFO_WORDS);
  localparam int unsigned BW = $clog2(2 * FIFO_WORDS + 1);

  localparam logic [AW:0] FULL_LEVEL = (AW + 1)'(FIFO_WORDS);
  // Almost-full above this word count
  localparam logic [AW:0] AF_LEVEL =
    (AW + 1)'(FIFO_WORDS - cam_stream_pkg::AFULL_MARGIN);
  localparam logic [BW-1:0] PKT_LEVEL = BW'(PKT_BYTES);

  // =========================================================================
  // Storage and pointers
  // =========================================================================

  cam_stream_pkg::pix_word_t mem [FIFO_WORDS];  // Word array

  logic [AW:0]               wr_ptr;    // Extra bit tells full from empty
  logic [AW:0]               rd_ptr;    // Word being read out
  logic [AW:0]               word_cnt;  // Words not yet fully read
  logic                      half_sel;  // 0 low byte next, 1 high byte next
  logic [BW-1:0]             byte_cnt;  // Bytes still to pop
  logic                      wr_ok;
  logic                      pop_ok;
  cam_stream_pkg::pix_word_t rd_word;

  assign word_cnt = wr_ptr - rd_ptr;
  assign rd_word  = mem[rd_ptr[AW-1:0]];

  // =========================================================================
  // Flags and handshakes
  // =========================================================================

  assign wr_if.full        = (word_cnt == FULL_LEVEL);
  assign wr_if.almost_full = (word_cnt > AF_LEVEL);

  assign wr_ok  = wr_if.wr_en & ~wr_if.full;  // Writes while full are lost
  assign pop_ok = usb_pop_i & (byte_cnt >= PKT_LEVEL);  // Whole packet present

  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      half_sel    <= 1'b0;
      byte_cnt    <= '0;
      usb_valid_o <= 1'b0;
    end else begin
      usb_valid_o <= pop_ok;  // Byte lands one cycle after the pop

      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end

      if (pop_ok) begin
        half_sel <= ~half_sel;
        if (half_sel) begin
          rd_ptr <= rd_ptr + 1'b1;  // High byte done, word freed
        end
      end

      // Two bytes in per word, one byte out per pop
      case ({wr_ok, pop_ok})
        2'b10:   byte_cnt <= byte_cnt + BW'(2);
        2'b01:   byte_cnt <= byte_cnt - 1'b1;
        2'b11:   byte_cnt <= byte_cnt + 1'b1;
        default: byte_cnt <= byte_cnt;
      endcase
    end
  end

  // =========================================================================
  // Memory write and byte output register
  // =========================================================================

  always_ff @(posedge cmos_pclk) begin
    if (wr_ok) begin
      mem[wr_ptr[AW-1:0]] <= wr_if.wr_data;
    end
    if (pop_ok) begin
      usb_byte_o <= half_sel ? rd_word[15:8] : rd_word[7:0];  // Low byte first
    end
  end

endmodule

`default_nettype wire

//--- verilog/frame_marker_insert.sv
`timescale 1ns/10ps
`default_nettype none

module frame_marker_insert #(
  parameter int unsigned MARKER_LEN = 1000  // Burst is MARKER_LEN+1 words
) (
  input  wire                            cmos_pclk,
  input  wire                            I_rst_n,
  input  wire                            vsync_i,   // Camera frame sync
  input  wire                            href_i,    // Camera data valid
  input  wire cam_stream_pkg::pix_word_t pix_i,     // Raw camera word
  pix_wr_if.writer                       wr_if,     // Towards the FIFO
  output logic                           cam_wr_o   // Camera word accepted
);

  localparam int unsigned CNT_W = $clog2(MARKER_LEN + 2);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(MARKER_LEN);

  // Field boundaries in the raw camera word
  localparam int unsigned G_LO = cam_stream_pkg::RED_W;
  localparam int unsigned B_LO = cam_stream_pkg::RED_W + cam_stream_pkg::GREEN_W;
  localparam int unsigned B_HI = B_LO + cam_stream_pkg::BLUE_W - 1;

  // =========================================================================
  // Colour field reorder
  // =========================================================================

  logic [cam_stream_pkg::RED_W-1:0]   red;
  logic [cam_stream_pkg::GREEN_W-1:0] green;
  logic [cam_stream_pkg::BLUE_W-1:0]  blue;
  cam_stream_pkg::pix_word_t          pix_swapped;

  assign red         = pix_i[G_LO-1:0];  // Low field moves to the top
  assign green       = pix_i[B_LO-1:G_LO];  // Middle stays in place
  assign blue        = pix_i[B_HI:B_LO];  // Top field drops to the bottom
  assign pix_swapped = {red, green, blue};

  // =========================================================================
  // Vsync edge and marker burst FSM
  // =========================================================================

  cam_stream_pkg::marker_state_e state_q;
  logic [CNT_W-1:0]              burst_cnt;  // Words emitted so far
  logic                          vsync_q;    // Previous vsync sample
  logic                          vsync_rise;
  logic                          in_burst;
  logic                          cam_wr;

  // Rises during a burst are ignored
  assign vsync_rise = vsync_i & ~vsync_q & (state_q == cam_stream_pkg::MARK_IDLE);
  assign in_burst   = (state_q == cam_stream_pkg::MARK_INSERT);

  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      vsync_q   <= 1'b0;
      state_q   <= cam_stream_pkg::MARK_IDLE;
      burst_cnt <= '0;
    end else begin
      vsync_q <= vsync_i;  // Edge detect history
      case (state_q)
        cam_stream_pkg::MARK_IDLE: begin
          if (vsync_rise) begin
            state_q   <= cam_stream_pkg::MARK_INSERT;  // Burst starts next cycle
            burst_cnt <= '0;
          end
        end
        cam_stream_pkg::MARK_INSERT: begin
          if (burst_cnt == LAST_CNT) begin
            state_q <= cam_stream_pkg::MARK_IDLE;  // Last marker word this cycle
          end else begin
            burst_cnt <= burst_cnt + 1'b1;
          end
        end
        default: begin
          state_q <= cam_stream_pkg::MARK_IDLE;
        end
      endcase
    end
  end

  // =========================================================================
  // Write mux
  // =========================================================================

  // Camera words held back near full, dropped during a burst
  assign cam_wr = ~in_burst & href_i & ~wr_if.almost_full;

  assign wr_if.wr_en   = in_burst | cam_wr;  // Markers ignore almost-full
  assign wr_if.wr_data = in_burst ? cam_stream_pkg::MARKER_WORD : pix_swapped;
  assign cam_wr_o      = cam_wr;  // Strobe for the frame-rate probe

endmodule

`default_nettype wire

//--- verilog/pix_wr_if.sv
`timescale 1ns/10ps
`default_nettype none

// Write path from the marker inserter into the packet FIFO
interface pix_wr_if;

  cam_stream_pkg::pix_word_t wr_data;  // Word to store
  logic                      wr_en;    // Store request, lost when full
  logic                      full;     // No free word slot
  logic                      almost_full;  // Fewer than AFULL_MARGIN slots free

  modport writer (
    output wr_data,
    output wr_en,
    input  full,
    input  almost_full
  );

  modport fifo (
    input  wr_data,
    input  wr_en,
    output full,
    output almost_full
  );

endinterface

`default_nettype wire

//--- verilog/cam_stream_pkg.sv
`default_nettype none

package cam_stream_pkg;

  // =========================================================================
  // Word and byte types
  // =========================================================================

  typedef logic [15:0] pix_word_t;  // Camera pixel and FIFO word
  typedef logic [7:0] usb_byte_t;   // One byte towards the USB side

  // =========================================================================
  // Marker inserter FSM
  // =========================================================================

  typedef enum logic {
    MARK_IDLE   = 1'b0,  // Camera words pass through
    MARK_INSERT = 1'b1   // Marker burst in progress
  } marker_state_e;

  localparam pix_word_t MARKER_WORD = 16'h0101;  // Start-of-frame filler word

  // =========================================================================
  // FIFO and pixel format constants
  // =========================================================================

  // Almost-full once fewer than this many word slots remain
  localparam int unsigned AFULL_MARGIN = 4;

  // RGB565 field widths after reordering, red on top
  localparam int unsigned RED_W   = 5;
  localparam int unsigned GREEN_W = 6;
  localparam int unsigned BLUE_W  = 5;

endpackage

`default_nettype wire
